//--- design/ipv4_pkg.sv
// Shared vector types and IPv4 header constants for the receive header checker

package ipv4_pkg;

    //////////////////////////////////////////////////////////////////////
    // Vector types

    // One 32-bit word of the incoming header stream
    typedef logic [31:0] ip_word_t;

    // Whole header without options, first word in the top bits
    typedef logic [159:0] ip_header_t;

    // One's-complement sum or checksum value
    typedef logic [15:0] csum_t;

    // IPv4 address
    typedef logic [31:0] ip_addr_t;

    // Total length field
    typedef logic [15:0] ip_len_t;

    // Protocol field
    typedef logic [7:0] ip_proto_t;

    //////////////////////////////////////////////////////////////////////
    // Constants

    // Only IPv4 is accepted
    localparam logic [3:0] IP_VERSION = 4'd4;

    // Header length in 32-bit words, options are not supported
    localparam logic [3:0] IP_IHL = 4'd5;

    // Words in a header without options
    localparam int HDR_WORDS = 5;

endpackage

//--- design/ipv4_header_deserializer.sv
// Header deserializer: collects five 32-bit word strobes into one header
// and issues a one-cycle header strobe

`timescale 1ns/1ns

module ipv4_header_deserializer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 word_valid,
    input  logic                 word_first,
    input  ipv4_pkg::ip_word_t   word,
    output logic                 header_valid,
    output ipv4_pkg::ip_header_t header
);

    // Counter spans 0 to HDR_WORDS
    localparam int CNT_WIDTH = $clog2(ipv4_pkg::HDR_WORDS + 1);

    logic [CNT_WIDTH-1:0] word_cnt;
    logic [CNT_WIDTH-1:0] word_cnt_next;
    logic                 word_take;
    logic                 hdr_done;
    ipv4_pkg::ip_header_t shift_reg;

    //////////////////////////////////////////////////////////////////////
    // Word acceptance

    // A first word always restarts; later words only count while a
    // header is open and not yet complete
    always_comb begin
        word_take     = 1'b0;
        word_cnt_next = word_cnt;
        if (word_valid) begin
            if (word_first) begin
                word_take     = 1'b1;
                word_cnt_next = CNT_WIDTH'(1);
            end else if ((word_cnt != '0) &&
                         (word_cnt < CNT_WIDTH'(ipv4_pkg::HDR_WORDS))) begin
                word_take     = 1'b1;
                word_cnt_next = word_cnt + CNT_WIDTH'(1);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt <= '0;
            hdr_done <= 1'b0;
        end else begin
            word_cnt <= word_cnt_next;
            hdr_done <= word_take &&
                        (word_cnt_next == CNT_WIDTH'(ipv4_pkg::HDR_WORDS));
        end
    end

    // Words enter at the bottom, so the first word ends up on top
    always_ff @(posedge clk) begin
        if (word_take) begin
            shift_reg <= {shift_reg[159-32:0], word};
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Header output

    // Output copy frees the shift register for a back-to-back header
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            header_valid <= 1'b0;
        end else begin
            header_valid <= hdr_done;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_done) begin
            header <= shift_reg;
        end
    end

endmodule

//--- design/ipv4_checksum_verify.sv
// Two-stage one's-complement checksum and format check over a whole
// IPv4 header

`timescale 1ns/1ns

module ipv4_checksum_verify (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 header_valid,
    input  ipv4_pkg::ip_header_t header,
    output logic                 chk_valid,
    output logic                 chk_ok,
    output ipv4_pkg::ip_header_t chk_header
);

    // Ten 16-bit halves in a header without options
    localparam int NUM_HALVES = 10;

    // Three halves per partial sum at most, so two carry bits
    localparam int PART_WIDTH = 18;

    // Four partial sums add up to at most twenty bits
    localparam int TOTAL_WIDTH = 20;

    ipv4_pkg::csum_t       half [NUM_HALVES];
    logic [PART_WIDTH-1:0] part [4];

    // Stage one registers
    logic                  s1_valid;
    ipv4_pkg::ip_header_t  s1_header;
    logic [PART_WIDTH-1:0] s1_part [4];

    // Stage two combinational terms
    logic [TOTAL_WIDTH-1:0] total;
    logic [16:0]            fold1;
    logic [16:0]            fold2;
    logic                   sum_ok;
    logic                   fmt_ok;

    //////////////////////////////////////////////////////////////////////
    // Stage one: split into halves and form partial sums

    always_comb begin
        for (int i = 0; i < NUM_HALVES; i++) begin
            half[i] = header[159 - 16*i -: 16];
        end
        part[0] = PART_WIDTH'(half[0]) + PART_WIDTH'(half[1]) +
                  PART_WIDTH'(half[2]);
        part[1] = PART_WIDTH'(half[3]) + PART_WIDTH'(half[4]) +
                  PART_WIDTH'(half[5]);
        part[2] = PART_WIDTH'(half[6]) + PART_WIDTH'(half[7]);
        part[3] = PART_WIDTH'(half[8]) + PART_WIDTH'(half[9]);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= header_valid;
        end
    end

    // Header rides along with its sums
    always_ff @(posedge clk) begin
        if (header_valid) begin
            s1_header <= header;
            for (int i = 0; i < 4; i++) begin
                s1_part[i] <= part[i];
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stage two: total, fold the carries, compare

    always_comb begin
        total = TOTAL_WIDTH'(s1_part[0]) + TOTAL_WIDTH'(s1_part[1]) +
                TOTAL_WIDTH'(s1_part[2]) + TOTAL_WIDTH'(s1_part[3]);
        // First fold leaves at most one carry, second fold clears it
        fold1 = 17'(total[15:0]) + 17'(total[TOTAL_WIDTH-1:16]);
        fold2 = 17'(fold1[15:0]) + 17'(fold1[16]);
        // Sum over a correct header, checksum included, is all ones
        sum_ok = (fold2[15:0] == 16'hffff);
        fmt_ok = (s1_header[159:156] == ipv4_pkg::IP_VERSION) &&
                 (s1_header[155:152] == ipv4_pkg::IP_IHL);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            chk_valid <= 1'b0;
            chk_ok    <= 1'b0;
        end else begin
            chk_valid <= s1_valid;
            if (s1_valid) begin
                chk_ok <= sum_ok && fmt_ok;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            chk_header <= s1_header;
        end
    end

endmodule

//--- design/ipv4_header_report.sv
// Header report: registered fields and verdict of each checked header,
// plus saturating counts of good and bad headers

`timescale 1ns/1ns

module ipv4_header_report #(
    parameter int COUNT_WIDTH = 16
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   chk_valid,
    input  logic                   chk_ok,
    input  ipv4_pkg::ip_header_t   chk_header,
    output logic                   hdr_valid,
    output logic                   hdr_ok,
    output ipv4_pkg::ip_addr_t     src_ip,
    output ipv4_pkg::ip_addr_t     dst_ip,
    output ipv4_pkg::ip_proto_t    protocol,
    output ipv4_pkg::ip_len_t      total_length,
    output logic [COUNT_WIDTH-1:0] good_count,
    output logic [COUNT_WIDTH-1:0] bad_count
);

    ipv4_pkg::ip_addr_t  hdr_src;
    ipv4_pkg::ip_addr_t  hdr_dst;
    ipv4_pkg::ip_proto_t hdr_proto;
    ipv4_pkg::ip_len_t   hdr_len;
    logic                good_full;
    logic                bad_full;

    //////////////////////////////////////////////////////////////////////
    // Field slicing

    // Word 0 holds the total length in its low half
    assign hdr_len   = chk_header[143:128];
    // Word 2 is TTL, protocol, checksum
    assign hdr_proto = chk_header[87:80];
    assign hdr_src   = chk_header[63:32];
    assign hdr_dst   = chk_header[31:0];

    //////////////////////////////////////////////////////////////////////
    // Registered report

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            hdr_valid <= 1'b0;
            hdr_ok    <= 1'b0;
        end else begin
            hdr_valid <= chk_valid;
            if (chk_valid) begin
                hdr_ok <= chk_ok;
            end
        end
    end

    // Fields hold until the next checked header
    always_ff @(posedge clk) begin
        if (chk_valid) begin
            src_ip       <= hdr_src;
            dst_ip       <= hdr_dst;
            protocol     <= hdr_proto;
            total_length <= hdr_len;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Saturating counters

    assign good_full = &good_count;
    assign bad_full  = &bad_count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            good_count <= '0;
            bad_count  <= '0;
        end else if (chk_valid) begin
            if (chk_ok && !good_full) begin
                good_count <= good_count + COUNT_WIDTH'(1);
            end
            if (!chk_ok && !bad_full) begin
                bad_count <= bad_count + COUNT_WIDTH'(1);
            end
        end
    end

endmodule

//--- design/ipv4_rx_check.sv
// Top level of the IPv4 receive header checker: deserializer, checksum
// verifier and report

`timescale 1ns/1ns

module ipv4_rx_check #(
    parameter int COUNT_WIDTH = 16
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   word_valid,
    input  logic                   word_first,
    input  ipv4_pkg::ip_word_t     word,
    output logic                   hdr_valid,
    output logic                   hdr_ok,
    output ipv4_pkg::ip_addr_t     src_ip,
    output ipv4_pkg::ip_addr_t     dst_ip,
    output ipv4_pkg::ip_proto_t    protocol,
    output ipv4_pkg::ip_len_t      total_length,
    output logic [COUNT_WIDTH-1:0] good_count,
    output logic [COUNT_WIDTH-1:0] bad_count
);

    // Deserializer to verifier
    logic                 header_valid;
    ipv4_pkg::ip_header_t header;

    // Verifier to report
    logic                 chk_valid;
    logic                 chk_ok;
    ipv4_pkg::ip_header_t chk_header;

    ipv4_header_deserializer u_deser (
        .clk          (clk),
        .rst_n        (rst_n),
        .word_valid   (word_valid),
        .word_first   (word_first),
        .word         (word),
        .header_valid (header_valid),
        .header       (header)
    );

    ipv4_checksum_verify u_verify (
        .clk          (clk),
        .rst_n        (rst_n),
        .header_valid (header_valid),
        .header       (header),
        .chk_valid    (chk_valid),
        .chk_ok       (chk_ok),
        .chk_header   (chk_header)
    );

    ipv4_header_report #(
        .COUNT_WIDTH (COUNT_WIDTH)
    ) u_report (
        .clk          (clk),
        .rst_n        (rst_n),
        .chk_valid    (chk_valid),
        .chk_ok       (chk_ok),
        .chk_header   (chk_header),
        .hdr_valid    (hdr_valid),
        .hdr_ok       (hdr_ok),
        .src_ip       (src_ip),
        .dst_ip       (dst_ip),
        .protocol     (protocol),
        .total_length (total_length),
        .good_count   (good_count),
        .bad_count    (bad_count)
    );

endmodule

//--- tb/ipv4_rx_check_properties.sv
// Bound checks for the IPv4 receive header checker: word-stream model of
// checksum, format, fields and report timing, with assertions on the outputs

`timescale 1ns/1ns

module ipv4_rx_check_properties #(
    parameter int COUNT_WIDTH = 16
) (
    input logic                   clk,
    input logic                   rst_n,
    input logic                   word_valid,
    input logic                   word_first,
    input ipv4_pkg::ip_word_t     word,
    input logic                   hdr_valid,
    input logic                   hdr_ok,
    input ipv4_pkg::ip_addr_t     src_ip,
    input ipv4_pkg::ip_addr_t     dst_ip,
    input ipv4_pkg::ip_proto_t    protocol,
    input ipv4_pkg::ip_len_t      total_length,
    input logic [COUNT_WIDTH-1:0] good_count,
    input logic [COUNT_WIDTH-1:0] bad_count
);

    // Expected report: ok, length, protocol, source, destination
    localparam int EXP_WIDTH = 1 + 16 + 8 + 32 + 32;

    int unsigned            fail_count = 0;
    logic [2:0]             word_cnt;
    logic [2:0]             word_cnt_next;
    logic                   word_take;
    ipv4_pkg::csum_t        run_sum;
    ipv4_pkg::csum_t        run_sum_next;
    logic                   fmt_match;
    ipv4_pkg::ip_len_t      len_seen;
    ipv4_pkg::ip_proto_t    proto_seen;
    ipv4_pkg::ip_addr_t     src_seen;
    // One stage per cycle from the fifth word to hdr_valid
    logic [4:0]             exp_valid;
    logic [EXP_WIDTH-1:0]   exp_report [5];
    logic [COUNT_WIDTH-1:0] exp_good;
    logic [COUNT_WIDTH-1:0] exp_bad;

    function automatic ipv4_pkg::csum_t add_ones(input ipv4_pkg::csum_t a,
                                                 input ipv4_pkg::csum_t b);
        logic [16:0] wide;
        wide = 17'(a) + 17'(b);
        return wide[15:0] + 16'(wide[16]);
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model

    always_comb begin
        word_take     = 1'b0;
        word_cnt_next = word_cnt;
        if (word_valid && word_first) begin
            word_take     = 1'b1;
            word_cnt_next = 3'd1;
        end else if (word_valid && (word_cnt != 3'd0) && (word_cnt != 3'd5)) begin
            word_take     = 1'b1;
            word_cnt_next = word_cnt + 3'd1;
        end
        run_sum_next = add_ones(add_ones(word_first ? 16'h0000 : run_sum, word[31:16]),
                                word[15:0]);
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            word_cnt  <= 3'd0;
            exp_valid <= 5'd0;
            exp_good  <= '0;
            exp_bad   <= '0;
        end else begin
            word_cnt  <= word_cnt_next;
            exp_valid <= {exp_valid[3:0], word_take && (word_cnt_next == 3'd5)};
            // Counters move on the edge that raises hdr_valid
            if (exp_valid[3] && exp_report[3][EXP_WIDTH-1] && (exp_good != '1)) begin
                exp_good <= exp_good + COUNT_WIDTH'(1);
            end
            if (exp_valid[3] && !exp_report[3][EXP_WIDTH-1] && (exp_bad != '1)) begin
                exp_bad <= exp_bad + COUNT_WIDTH'(1);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (word_take) begin
            run_sum <= run_sum_next;
        end
        if (word_take && (word_cnt_next == 3'd1)) begin
            fmt_match <= (word[31:28] == ipv4_pkg::IP_VERSION) &&
                         (word[27:24] == ipv4_pkg::IP_IHL);
            len_seen  <= word[15:0];
        end
        if (word_take && (word_cnt_next == 3'd3)) begin
            proto_seen <= word[23:16];
        end
        if (word_take && (word_cnt_next == 3'd4)) begin
            src_seen <= word;
        end
        exp_report[0] <= {(run_sum_next == 16'hffff) && fmt_match, len_seen, proto_seen,
                          src_seen, word};
        for (int i = 1; i < 5; i++) begin
            exp_report[i] <= exp_report[i-1];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Assertions

    a_timing: assert property (@(posedge clk) disable iff (!rst_n)
        hdr_valid == exp_valid[4])
        else begin
            $error("FAIL hdr_valid: got %h expected %h", $sampled(hdr_valid),
                   $sampled(exp_valid[4]));
            fail_count++;
        end

    a_verdict: assert property (@(posedge clk) disable iff (!rst_n)
        hdr_valid |-> (hdr_ok == exp_report[4][EXP_WIDTH-1]))
        else begin
            $error("FAIL hdr_ok: got %h expected %h", $sampled(hdr_ok),
                   $sampled(exp_report[4][EXP_WIDTH-1]));
            fail_count++;
        end

    a_fields: assert property (@(posedge clk) disable iff (!rst_n)
        hdr_valid |-> ({total_length, protocol, src_ip, dst_ip} == exp_report[4][87:0]))
        else begin
            $error("FAIL total_length/protocol/src_ip/dst_ip: got %h %h %h %h expected %h",
                   $sampled(total_length), $sampled(protocol), $sampled(src_ip),
                   $sampled(dst_ip), $sampled(exp_report[4][87:0]));
            fail_count++;
        end

    a_counts: assert property (@(posedge clk) disable iff (!rst_n)
        (good_count == exp_good) && (bad_count == exp_bad))
        else begin
            $error("FAIL good_count/bad_count: got %h %h expected %h %h",
                   $sampled(good_count), $sampled(bad_count), $sampled(exp_good),
                   $sampled(exp_bad));
            fail_count++;
        end

    // Outputs are quiet on the first edge out of reset
    a_reset: assert property (@(posedge clk) $rose(rst_n) |->
        (!hdr_valid && !hdr_ok && (good_count == '0) && (bad_count == '0)))
        else begin
            $error("FAIL after reset: hdr_valid %h hdr_ok %h good_count %h bad_count %h",
                   $sampled(hdr_valid), $sampled(hdr_ok), $sampled(good_count),
                   $sampled(bad_count));
            fail_count++;
        end

endmodule

bind ipv4_rx_check ipv4_rx_check_properties #(.COUNT_WIDTH(COUNT_WIDTH)) u_props (.*);

//--- tb/ipv4_rx_check_tb.sv
// Testbench for the IPv4 receive header checker: LFSR-driven headers,
// one line per test and the closing counts

`timescale 1ns/1ns

module ipv4_rx_check_tb;

    localparam int COUNT_WIDTH = 16;
    // Longest wait for reports, in clock cycles
    localparam int WAIT_LIMIT  = 40;

    logic                   clk;
    logic                   rst_n;
    logic                   word_valid;
    logic                   word_first;
    ipv4_pkg::ip_word_t     word;
    logic                   hdr_valid;
    logic                   hdr_ok;
    ipv4_pkg::ip_addr_t     src_ip;
    ipv4_pkg::ip_addr_t     dst_ip;
    ipv4_pkg::ip_proto_t    protocol;
    ipv4_pkg::ip_len_t      total_length;
    logic [COUNT_WIDTH-1:0] good_count;
    logic [COUNT_WIDTH-1:0] bad_count;

    logic [31:0]        lfsr_state;
    ipv4_pkg::ip_word_t hdr_words [5];
    logic               hdr_is_good;
    int unsigned        reports_seen;
    int unsigned        tb_errors;
    int unsigned        errors_at_start;
    int unsigned        tests_done;
    int unsigned        tests_failed;
    int unsigned        sent_good;
    int unsigned        sent_bad;

    ipv4_rx_check #(.COUNT_WIDTH(COUNT_WIDTH)) DUT (
        .clk          (clk),
        .rst_n        (rst_n),
        .word_valid   (word_valid),
        .word_first   (word_first),
        .word         (word),
        .hdr_valid    (hdr_valid),
        .hdr_ok       (hdr_ok),
        .src_ip       (src_ip),
        .dst_ip       (dst_ip),
        .protocol     (protocol),
        .total_length (total_length),
        .good_count   (good_count),
        .bad_count    (bad_count)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #50 clk = ~clk;
        end
    end

    // Count report strobes as they go by
    always @(posedge clk) begin
        if (hdr_valid) begin
            reports_seen <= reports_seen + 1;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stimulus helpers

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
    endfunction

    function automatic logic [31:0] random_bits(input int count);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value      = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // One's-complement sum of the ten halves, end-around carries folded in
    function automatic ipv4_pkg::csum_t ones_sum(input ipv4_pkg::ip_word_t words [5]);
        logic [31:0] acc;
        acc = '0;
        for (int i = 0; i < 5; i++) begin
            acc = acc + 32'(words[i][31:16]) + 32'(words[i][15:0]);
        end
        while (acc[31:16] != 16'h0000) begin
            acc = 32'(acc[15:0]) + 32'(acc[31:16]);
        end
        return acc[15:0];
    endfunction

    task automatic build_header(input logic [3:0] version, input logic [3:0] ihl,
                                input logic bad_sum);
        ipv4_pkg::csum_t csum;
        ipv4_pkg::csum_t wrong;
        hdr_words[0] = {version, ihl, 8'(random_bits(8)), 16'(random_bits(16))};
        hdr_words[1] = random_bits(32);
        hdr_words[2] = {16'(random_bits(16)), 16'h0000};
        hdr_words[3] = random_bits(32);
        hdr_words[4] = random_bits(32);
        csum  = ~ones_sum(hdr_words);
        wrong = 16'(random_bits(16));
        // 0000 and ffff stand for the same value
        if ((wrong == csum) ||
            (((wrong ^ csum) == 16'hffff) && ((csum == 16'h0000) || (csum == 16'hffff)))) begin
            wrong = csum ^ 16'h0001;
        end
        hdr_words[2][15:0] = bad_sum ? wrong : csum;
        hdr_is_good = !bad_sum && (version == 4'd4) && (ihl == 4'd5);
    endtask

    task automatic send_words(input int count);
        for (int i = 0; i < count; i++) begin
            @(posedge clk);
            word_valid <= 1'b1;
            word_first <= (i == 0);
            word       <= hdr_words[i];
        end
    endtask

    task automatic send_header();
        send_words(5);
        if (hdr_is_good) begin
            sent_good++;
        end else begin
            sent_bad++;
        end
    endtask

    task automatic go_idle();
        @(posedge clk);
        word_valid <= 1'b0;
        word_first <= 1'b0;
    endtask

    task automatic wait_reports(input int unsigned base, input int unsigned count);
        int cycles;
        cycles = 0;
        while ((reports_seen - base < count) && (cycles < WAIT_LIMIT)) begin
            @(posedge clk);
            cycles++;
        end
        if (reports_seen - base < count) begin
            $display("Timeout: only %0d of %0d reports arrived within %0d cycles",
                     reports_seen - base, count, WAIT_LIMIT);
            tb_errors++;
        end
    endtask

    task automatic run_single(input logic [3:0] version, input logic [3:0] ihl,
                              input logic bad_sum);
        int unsigned base;
        base = reports_seen;
        build_header(version, ihl, bad_sum);
        send_header();
        go_idle();
        wait_reports(base, 1);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test bookkeeping

    function automatic int unsigned error_total();
        return DUT.u_props.fail_count + tb_errors;
    endfunction

    task automatic open_test();
        errors_at_start = error_total();
    endtask

    task automatic close_test(input string name);
        int unsigned errs;
        repeat (2) @(posedge clk);
        errs = error_total() - errors_at_start;
        tests_done++;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %0d %-20s %s (%0d errors)", tests_done, name,
                 (errs == 0) ? "ok" : "failed", errs);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Test sequence

    initial begin
        int unsigned base;
        logic [3:0]  odd_version;
        lfsr_state   = 32'h44c4_6045;
        rst_n        = 1'b0;
        word_valid   = 1'b0;
        word_first   = 1'b0;
        word         = '0;
        reports_seen = 0;
        tb_errors    = 0;
        tests_done   = 0;
        tests_failed = 0;
        sent_good    = 0;
        sent_bad     = 0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;

        open_test();
        for (int i = 0; i < 8; i++) begin
            run_single(4'd4, 4'd5, 1'b0);
        end
        close_test("good headers");

        open_test();
        for (int i = 0; i < 8; i++) begin
            run_single(4'd4, 4'd5, 1'b1);
        end
        close_test("bad checksum");

        // Checksum right for the contents, format wrong
        open_test();
        run_single(4'd6, 4'd5, 1'b0);
        run_single(4'd4, 4'd6, 1'b0);
        run_single(4'd4, 4'd4, 1'b0);
        for (int i = 0; i < 3; i++) begin
            odd_version = 4'(random_bits(4));
            if (odd_version == 4'd4) begin
                odd_version = 4'd7;
            end
            run_single(odd_version, 4'd5, 1'b0);
        end
        close_test("bad version or IHL");

        open_test();
        base = reports_seen;
        for (int i = 0; i < 5; i++) begin
            build_header(4'd4, 4'd5, i == 2);
            send_header();
        end
        go_idle();
        wait_reports(base, 5);
        close_test("back to back");

        // Restart in mid header, then check the totals
        open_test();
        base = reports_seen;
        build_header(4'd4, 4'd5, 1'b0);
        send_words(2);
        build_header(4'd4, 4'd5, 1'b0);
        send_header();
        build_header(4'd4, 4'd5, 1'b1);
        send_words(3);
        go_idle();
        build_header(4'd4, 4'd5, 1'b1);
        send_header();
        go_idle();
        wait_reports(base, 2);
        repeat (6) @(posedge clk);
        assert (reports_seen - base == 2) else begin
            $display("FAIL hdr_valid pulses: got %h expected %h", reports_seen - base, 2);
            tb_errors++;
        end
        assert (good_count == COUNT_WIDTH'(sent_good)) else begin
            $display("FAIL good_count: got %h expected %h", good_count, sent_good);
            tb_errors++;
        end
        assert (bad_count == COUNT_WIDTH'(sent_bad)) else begin
            $display("FAIL bad_count: got %h expected %h", bad_count, sent_bad);
            tb_errors++;
        end
        close_test("restart and totals");

        // A good verdict and nonzero counts for the reset to clear
        open_test();
        run_single(4'd4, 4'd5, 1'b0);
        @(posedge clk);
        rst_n <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        close_test("reset state");

        $display("Summary: %0d tests, %0d failed, %0d assertion errors, %0d testbench errors",
                 tests_done, tests_failed, DUT.u_props.fail_count, tb_errors);
        if ((tests_failed == 0) && (error_total() == 0)) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- ipv4_rx_check.f
design/ipv4_pkg.sv
design/ipv4_header_deserializer.sv
design/ipv4_checksum_verify.sv
design/ipv4_header_report.sv
design/ipv4_rx_check.sv
tb/ipv4_rx_check_properties.sv
tb/ipv4_rx_check_tb.sv

//--- Makefile
# Verilator build and run of the IPv4 receive header checker testbench
# Targets: compile, run, clean

VERILATOR ?= verilator
TOP       ?= ipv4_rx_check_tb
FILELIST  ?= ipv4_rx_check.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000
SOURCES   := $(wildcard design/*.sv tb/*.sv)
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	$(SIM_BIN) $(SIM_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if grep -q '\*\* FAIL \*\*' $(LOG); then \
		echo "Simulation failed, see $(LOG)"; exit 1; \
	fi; \
	if [ $$status -ne 0 ]; then \
		echo "Simulator exited with status $$status"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
